//--- Makefile
TOP = exec_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f all.f --top-module $(TOP)

obj_dir/V$(TOP): all.f verilog/*.sv verilog/*.svh verif/*.sv
	verilator --binary --timing --assert -f all.f --top-module $(TOP)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "^TEST PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- all.f
+incdir+verilog
verilog/isa_pkg.sv
verilog/exec_pkg.sv
verilog/operand_sel.sv
verilog/int_alu.sv
verilog/hilo_muldiv.sv
verilog/exec_stage.sv
verif/exec_properties.sv
verif/exec_tb.sv

//--- verif/exec_properties.sv
//////////////////////////////////////////////////////////////////////
// bound assertions for the execute stage
// response strobe, busy length, hi/lo requests while busy
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "exec_consts.svh"

module exec_properties
    import isa_pkg::*;
    import exec_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input exec_req_t req_i,
    input exec_rsp_t rsp_i,
    input logic      md_busy_i
);

    logic hilo_wr;
    logic hilo_any;

    assign hilo_wr  = req_i.valid && (req_i.func inside {ALU_MULT, ALU_MULTU, ALU_DIV,
                                                         ALU_DIVU, ALU_MTHI, ALU_MTLO});
    assign hilo_any = hilo_wr || (req_i.valid && (req_i.func inside {ALU_MFHI, ALU_MFLO}));

    // mul/div and moves write hi/lo only
    a_no_rsp: assert property (@(posedge clk) disable iff (!rst)
        hilo_wr |=> !rsp_i.valid)
        else $error("response strobe after a multiply, divide or move");

    // iterations plus the fixup cycle
    a_busy_len: assert property (@(posedge clk) disable iff (!rst)
        $fell(md_busy_i) |-> $past(md_busy_i, `MD_ITERS + 1) && !$past(md_busy_i, `MD_ITERS + 2))
        else $error("busy pulse length differs from the iteration count plus one");

    a_no_req_busy: assert property (@(posedge clk) disable iff (!rst)
        hilo_any |-> !md_busy_i)
        else $error("hi/lo request while the multiply/divide unit is busy");

endmodule

bind exec_stage exec_properties u_exec_properties (
    .clk       (clk),
    .rst       (rst),
    .req_i     (req_i),
    .rsp_i     (rsp_o),
    .md_busy_i (md_busy_o)
);

//--- verif/exec_tb.sv
//////////////////////////////////////////////////////////////////////
// testbench for the execute stage
// LFSR stimulus, reference model, directed tests, compare tasks
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "exec_consts.svh"

module exec_tb
    import isa_pkg::*;
    import exec_pkg::*;
();

    localparam int N_ALU = 200;
    localparam int N_MD  = 200;
    // about four cycles per single-cycle op, busy run plus reads per mul/div
    localparam int LIMIT = 2 * (16 + 4 * (N_ALU + 16 + 96 + 32 + 32 + 10)
                                + N_MD * (`MD_ITERS + 14));

    logic      clk;
    logic      rst;
    exec_req_t req_i;
    fwd_bus_t  fwd_i;
    exec_rsp_t rsp_o;
    word_t     store_data_o;
    logic      md_busy_o;

    logic [31:0] lfsr_state;
    int          errors = 0;
    int          cycles = 0;

    exec_stage u_exec_stage (
        .clk          (clk),
        .rst          (rst),
        .req_i        (req_i),
        .fwd_i        (fwd_i),
        .rsp_o        (rsp_o),
        .store_data_o (store_data_o),
        .md_busy_o    (md_busy_o)
    );

    always #2 clk = ~clk;

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT)
        begin
            $display("timeout: run did not finish within %0d cycles", LIMIT);
            $display("TEST FAIL");
            $finish;
        end
    end

    // fibonacci LFSR, taps 32 22 2 1
    function automatic word_t rand_bits(input int n);
        word_t val;
        logic  fb;
        val = '0;
        for (int i = 0; i < n; i++)
        begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            val        = {val[30:0], fb};
        end
        return val;
    endfunction

    // expected result of the single-cycle functions
    function automatic word_t alu_model(input alu_func_e f, input word_t a, input word_t b);
        logic [`SHAMT_W-1:0] sh;
        word_t               r;
        sh = a[`SHAMT_W-1:0];
        case (f)
            ALU_PA:   r = a;
            ALU_PB:   r = b;
            ALU_ADD:  r = a + b;
            ALU_SUB:  r = a - b;
            ALU_AND:  r = a & b;
            ALU_OR:   r = a | b;
            ALU_XOR:  r = a ^ b;
            ALU_NOR:  r = ~(a | b);
            ALU_SLT:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU: r = (a < b) ? 32'd1 : 32'd0;
            ALU_SLL:  r = b << sh;
            ALU_SRL:  r = b >> sh;
            ALU_SRA:  r = $signed(b) >>> sh;
            default:  r = '0;
        endcase
        return r;
    endfunction

    task automatic check_word(input word_t exp, input word_t act, input string what);
        if (act !== exp)
        begin
            errors++;
            $display("[ERROR] %0t: %s expected %h got %h", $time, what, exp, act);
        end
    endtask

    task automatic check_rsp(input exec_rsp_t exp, input exec_rsp_t act, input string what);
        if (act !== exp)
        begin
            errors++;
            $display("[ERROR] %0t: %s expected valid %b result %h, got valid %b result %h",
                     $time, what, exp.valid, exp.result, act.valid, act.result);
        end
    endtask

    // rs/rt taken straight from the register operands
    function automatic exec_req_t plain_req(input alu_func_e f, input word_t a, input word_t b);
        exec_req_t r;
        r         = '0;
        r.valid   = 1'b1;
        r.func    = f;
        r.opa_sel = OPA_RS;
        r.opb_sel = OPB_RT;
        r.rs_fwd  = FWD_NONE;
        r.rt_fwd  = FWD_NONE;
        r.rs      = a;
        r.rt      = b;
        r.ext     = rand_bits(32);
        return r;
    endfunction

    // returns just after the edge that takes the strobe
    task automatic issue(input exec_req_t r);
        @(posedge clk);
        req_i <= r;
        @(posedge clk);
        req_i.valid <= 1'b0;
    endtask

    task automatic alu_check(input exec_req_t r, input word_t exp, input string what);
        exec_rsp_t want;
        want = '{valid: 1'b1, result: exp};
        issue(r);
        @(negedge clk);
        check_rsp(want, rsp_o, what);
        @(negedge clk);
        if (rsp_o.valid)
        begin
            errors++;
            $display("response strobe stayed high a second cycle at %0t (%s)", $time, what);
        end
    endtask

    task automatic wait_md_idle();
        int n;
        n = 0;
        while (md_busy_o && n < 4 * `MD_ITERS)
        begin
            @(negedge clk);
            n++;
        end
        if (md_busy_o)
        begin
            errors++;
            $display("multiply/divide unit still busy after %0d cycles", n);
        end
    endtask

    task automatic test_reset();
        repeat (4)
        begin
            @(negedge clk);
            if (rsp_o.valid || md_busy_o)
            begin
                errors++;
                $display("strobe or busy high after reset without a request at %0t", $time);
            end
        end
        alu_check(plain_req(ALU_MFHI, '0, '0), '0, "mfhi after reset");
        alu_check(plain_req(ALU_MFLO, '0, '0), '0, "mflo after reset");
    endtask

    task automatic test_alu();
        alu_func_e ops [11] = '{ALU_PA, ALU_PB, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
                                ALU_XOR, ALU_NOR, ALU_SLT, ALU_SLTU, ALU_NOP};
        alu_func_e f;
        word_t     a;
        word_t     b;
        int        k;
        // slt against sltu with opposite signs
        for (int j = 0; j < 8; j++)
        begin
            a     = rand_bits(32);
            b     = rand_bits(31);
            b[31] = ~a[31];
            alu_check(plain_req(ALU_SLT, a, b), alu_model(ALU_SLT, a, b), "slt mixed");
            alu_check(plain_req(ALU_SLTU, a, b), alu_model(ALU_SLTU, a, b), "sltu mixed");
        end
        for (int i = 0; i < N_ALU; i++)
        begin
            k = int'(rand_bits(8) % 11);
            f = ops[k];
            a = rand_bits(32);
            b = rand_bits(32);
            alu_check(plain_req(f, a, b), alu_model(f, a, b), f.name());
        end
    endtask

    task automatic test_shift();
        word_t a;
        word_t b;
        for (int sh = 0; sh < 32; sh++)
        begin
            a = (rand_bits(32) & ~32'h1f) | word_t'(sh);  // junk above the amount
            b = rand_bits(32);
            alu_check(plain_req(ALU_SLL, a, b), alu_model(ALU_SLL, a, b), "sll");
            alu_check(plain_req(ALU_SRL, a, b), alu_model(ALU_SRL, a, b), "srl");
            b = b | 32'h8000_0000;
            alu_check(plain_req(ALU_SRA, a, b), alu_model(ALU_SRA, a, b), "sra negative");
        end
    endtask

    task automatic test_forward();
        exec_req_t r;
        fwd_bus_t  fb;
        word_t     rs_new;
        word_t     rt_new;
        word_t     a;
        word_t     b;
        for (int i = 0; i < 32; i++)
        begin
            fb.alu_res = rand_bits(32);
            fb.mem_res = rand_bits(32);
            r          = plain_req(ALU_SUB, rand_bits(32), rand_bits(32));
            r.rs_fwd   = i[0] ? FWD_MEM : FWD_ALU;
            r.rt_fwd   = i[1] ? FWD_MEM : FWD_ALU;
            r.opa_sel  = i[2] ? OPA_EXT : OPA_RS;
            r.opb_sel  = i[3] ? OPB_EXT : OPB_RT;
            rs_new     = (r.rs_fwd == FWD_MEM) ? fb.mem_res : fb.alu_res;
            rt_new     = (r.rt_fwd == FWD_MEM) ? fb.mem_res : fb.alu_res;
            a          = (r.opa_sel == OPA_EXT) ? r.ext : rs_new;
            b          = (r.opb_sel == OPB_EXT) ? r.ext : rt_new;
            @(posedge clk);
            fwd_i <= fb;
            alu_check(r, a - b, "forwarded sub");   // sub catches swapped operands
            check_word(rt_new, store_data_o, "store data");
        end
    endtask

    task automatic test_muldiv();
        alu_func_e   ops [4] = '{ALU_MULT, ALU_MULTU, ALU_DIV, ALU_DIVU};
        alu_func_e   f;
        word_t       a;
        word_t       b;
        longint      la;
        longint      lb;
        logic [63:0] want;
        for (int i = 0; i < N_MD; i++)
        begin
            f = ops[int'(rand_bits(2))];
            a = rand_bits(32);
            b = rand_bits(32) >> rand_bits(5);     // spread of divisor sizes
            if (b == '0)
                b = 32'd1;
            if (f inside {ALU_MULT, ALU_DIV})
            begin
                la = longint'($signed(a));
                lb = longint'($signed(b));
            end
            else
            begin
                la = longint'({32'd0, a});
                lb = longint'({32'd0, b});
            end
            if (f == ALU_MULTU)
                want = {32'd0, a} * {32'd0, b};
            else if (f == ALU_MULT)
                want = la * lb;
            else
                want = {32'(la % lb), 32'(la / lb)};   // remainder keeps dividend sign
            issue(plain_req(f, a, b));
            @(negedge clk);
            if (!md_busy_o || rsp_o.valid)
            begin
                errors++;
                $display("%s at %0t did not raise busy or gave a response", f.name(), $time);
            end
            wait_md_idle();
            alu_check(plain_req(ALU_MFHI, '0, '0), want[63:32], {f.name(), " hi"});
            alu_check(plain_req(ALU_MFLO, '0, '0), want[31:0], {f.name(), " lo"});
        end
    endtask

    task automatic test_move();
        word_t h;
        word_t l;
        for (int i = 0; i < 8; i++)
        begin
            h = rand_bits(32);
            l = rand_bits(32);
            issue(plain_req(ALU_MTHI, h, rand_bits(32)));
            issue(plain_req(ALU_MTLO, l, rand_bits(32)));
            alu_check(plain_req(ALU_MFHI, '0, '0), h, "mfhi after mthi");
            alu_check(plain_req(ALU_MFLO, '0, '0), l, "mflo after mtlo");
        end
    endtask

    initial
    begin
        clk        = 1'b0;
        rst        = 1'b0;
        req_i      = '0;
        fwd_i      = '0;
        lfsr_state = 32'h2fdd_54bb;
        repeat (16) @(posedge clk);
        rst <= 1'b1;
        test_reset();
        test_alu();
        test_shift();
        test_forward();
        test_muldiv();
        test_move();
        $display("exec_tb finished with %0d errors", errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

//--- verilog/exec_consts.svh
//////////////////////////////////////////////////////////////////////
// execute stage constants
// word width, shift amount width, multiply/divide iteration count
//////////////////////////////////////////////////////////////////////

`ifndef EXEC_CONSTS_SVH
`define EXEC_CONSTS_SVH

// machine word
`define XLEN     32

// low bits of operand A used as shift amount
`define SHAMT_W  5

// one iteration per result bit, sign fixup cycle comes on top
`define MD_ITERS 32

`endif

//--- verilog/exec_pkg.sv
//////////////////////////////////////////////////////////////////////
// execute stage data types
// machine word, request, forwarding bus and response structs
//////////////////////////////////////////////////////////////////////

`include "exec_consts.svh"

package exec_pkg;

    import isa_pkg::*;

    typedef logic [`XLEN-1:0] word_t;

    // one instruction issued into the stage
    typedef struct packed {
        logic      valid;
        alu_func_e func;
        opa_sel_e  opa_sel;
        opb_sel_e  opb_sel;
        fwd_sel_e  rs_fwd;
        fwd_sel_e  rt_fwd;
        word_t     rs;      // register file values, may be stale
        word_t     rt;
        word_t     ext;     // sign-extended immediate
    } exec_req_t;

    typedef struct packed {
        word_t alu_res;
        word_t mem_res;
    } fwd_bus_t;

    typedef struct packed {
        logic  valid;
        word_t result;
    } exec_rsp_t;

endpackage

//--- verilog/exec_stage.sv
//////////////////////////////////////////////////////////////////////
// execute stage top
// operand select, ALU, multiply/divide unit and result register
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module exec_stage
    import isa_pkg::*;
    import exec_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  exec_req_t req_i,
    input  fwd_bus_t  fwd_i,
    output exec_rsp_t rsp_o,
    output word_t     store_data_o,
    output logic      md_busy_o
);

    word_t opa;
    word_t opb;
    word_t alu_res;
    word_t hilo_res;
    word_t res_d;
    logic  hilo_wr;     // ops that only touch hi/lo
    logic  md_start;
    logic  rsp_valid;
    word_t rsp_result;

    assign hilo_wr  = req_i.func inside {ALU_MULT, ALU_MULTU, ALU_DIV, ALU_DIVU,
                                         ALU_MTHI, ALU_MTLO};
    assign md_start = req_i.valid && hilo_wr;

    operand_sel u_operand_sel (
        .req_i        (req_i),
        .fwd_i        (fwd_i),
        .opa_o        (opa),
        .opb_o        (opb),
        .store_data_o (store_data_o)
    );

    int_alu u_int_alu (
        .func_i (req_i.func),
        .opa_i  (opa),
        .opb_i  (opb),
        .res_o  (alu_res)
    );

    hilo_muldiv u_hilo_muldiv (
        .clk     (clk),
        .rst     (rst),
        .start_i (md_start),
        .func_i  (req_i.func),
        .opa_i   (opa),
        .opb_i   (opb),
        .hilo_o  (hilo_res),
        .busy_o  (md_busy_o)
    );

    assign res_d = (req_i.func inside {ALU_MFHI, ALU_MFLO}) ? hilo_res : alu_res;

    always_ff @(posedge clk)
    begin
        if (!rst)
            rsp_valid <= 1'b0;
        else
            rsp_valid <= req_i.valid && !hilo_wr;  // one-cycle strobe
    end

    always_ff @(posedge clk)
    begin
        if (req_i.valid)
            rsp_result <= res_d;
    end

    assign rsp_o = '{valid: rsp_valid, result: rsp_result};

endmodule

//--- verilog/hilo_muldiv.sv
//////////////////////////////////////////////////////////////////////
// iterative multiply/divide unit with hi/lo registers
// shift-and-add multiply, restoring divide, sign fixup cycle
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "exec_consts.svh"

module hilo_muldiv
    import isa_pkg::*;
    import exec_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      start_i,
    input  alu_func_e func_i,
    input  word_t     opa_i,
    input  word_t     opb_i,
    output word_t     hilo_o,
    output logic      busy_o
);

    localparam int CNT_W = $clog2(`MD_ITERS + 1);

    logic               busy;
    logic [CNT_W-1:0]   cnt;
    logic               last;
    word_t              hi;
    word_t              lo;
    word_t              work_hi;    // partial product high / remainder
    word_t              work_lo;    // multiplier bits / quotient bits
    word_t              b_mag;
    logic               is_mul;
    logic               neg_q;
    logic               neg_r;
    logic               md_op;
    logic               op_mul;
    logic               op_signed;
    logic               a_neg;
    logic               b_neg;
    word_t              a_abs;
    word_t              b_abs;
    logic [`XLEN:0]     mul_sum;
    logic [`XLEN:0]     div_shift;
    logic [`XLEN:0]     div_diff;
    logic [2*`XLEN-1:0] prod;
    logic [2*`XLEN-1:0] prod_fix;

    assign md_op     = func_i inside {ALU_MULT, ALU_MULTU, ALU_DIV, ALU_DIVU};
    assign op_mul    = func_i inside {ALU_MULT, ALU_MULTU};
    assign op_signed = func_i inside {ALU_MULT, ALU_DIV};
    assign a_neg     = op_signed && opa_i[`XLEN-1];
    assign b_neg     = op_signed && opb_i[`XLEN-1];
    assign a_abs     = a_neg ? -opa_i : opa_i;
    assign b_abs     = b_neg ? -opb_i : opb_i;

    // one multiply step, carry kept in bit XLEN
    assign mul_sum   = {1'b0, work_hi} + (work_lo[0] ? {1'b0, b_mag} : '0);
    // one divide step, borrow in bit XLEN means restore
    assign div_shift = {work_hi, work_lo[`XLEN-1]};
    assign div_diff  = div_shift - {1'b0, b_mag};

    assign last     = (cnt == CNT_W'(`MD_ITERS));
    assign prod     = {work_hi, work_lo};
    assign prod_fix = neg_q ? -prod : prod;

    always_ff @(posedge clk)
    begin
        if (!busy && start_i && md_op)
        begin
            work_hi <= '0;
            work_lo <= a_abs;
            b_mag   <= b_abs;
            is_mul  <= op_mul;
            neg_q   <= a_neg ^ b_neg;
            neg_r   <= a_neg;       // remainder follows the dividend
        end
        else if (busy && !last)
        begin
            if (is_mul)
            begin
                work_hi <= mul_sum[`XLEN:1];
                work_lo <= {mul_sum[0], work_lo[`XLEN-1:1]};
            end
            else
            begin
                work_hi <= div_diff[`XLEN] ? div_shift[`XLEN-1:0] : div_diff[`XLEN-1:0];
                work_lo <= {work_lo[`XLEN-2:0], ~div_diff[`XLEN]};
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            busy <= 1'b0;
            cnt  <= '0;
            hi   <= '0;
            lo   <= '0;
        end
        else if (busy)
        begin
            if (last)
            begin
                busy <= 1'b0;   // fixup cycle
                if (is_mul)
                    {hi, lo} <= prod_fix;
                else
                begin
                    lo <= neg_q ? -work_lo : work_lo;
                    hi <= neg_r ? -work_hi : work_hi;
                end
            end
            else
                cnt <= cnt + 1'b1;
        end
        else if (start_i)
        begin
            if (md_op)
            begin
                busy <= 1'b1;
                cnt  <= '0;
            end
            else if (func_i == ALU_MTHI)
                hi <= opa_i;
            else if (func_i == ALU_MTLO)
                lo <= opa_i;
        end
    end

    always_comb
    begin
        case (func_i)
            ALU_MFHI: hilo_o = hi;
            ALU_MFLO: hilo_o = lo;
            default:  hilo_o = '0;
        endcase
    end

    assign busy_o = busy;

endmodule

//--- verilog/int_alu.sv
//////////////////////////////////////////////////////////////////////
// integer ALU
// add/sub, logic ops, set-less-than and a 32-bit barrel shifter
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "exec_consts.svh"

module int_alu
    import isa_pkg::*;
    import exec_pkg::*;
(
    input  alu_func_e func_i,
    input  word_t     opa_i,
    input  word_t     opb_i,
    output word_t     res_o
);

    logic [`SHAMT_W-1:0] shamt;
    logic                sh_fill;
    word_t               opb_rev;
    word_t               sh_in;
    logic [2*`XLEN-1:0]  sh_wide;
    word_t               sh_out;
    word_t               sll_res;
    logic                lt_s;
    logic                lt_u;

    assign shamt = opa_i[`SHAMT_W-1:0];

    // left shift runs through the right shifter on bit-reversed data
    assign opb_rev = {<<{opb_i}};
    assign sh_in   = (func_i == ALU_SLL) ? opb_rev : opb_i;
    assign sh_fill = (func_i == ALU_SRA) && opb_i[`XLEN-1];
    assign sh_wide = {{`XLEN{sh_fill}}, sh_in} >> shamt;   // upper half supplies fill bits
    assign sh_out  = sh_wide[`XLEN-1:0];
    assign sll_res = {<<{sh_out}};

    assign lt_s = $signed(opa_i) < $signed(opb_i);
    assign lt_u = opa_i < opb_i;

    always_comb
    begin
        case (func_i)
            ALU_PA:   res_o = opa_i;
            ALU_PB:   res_o = opb_i;
            ALU_ADD:  res_o = opa_i + opb_i;
            ALU_SUB:  res_o = opa_i - opb_i;
            ALU_AND:  res_o = opa_i & opb_i;
            ALU_OR:   res_o = opa_i | opb_i;
            ALU_XOR:  res_o = opa_i ^ opb_i;
            ALU_NOR:  res_o = ~(opa_i | opb_i);
            ALU_SLT:  res_o = {{(`XLEN-1){1'b0}}, lt_s};
            ALU_SLTU: res_o = {{(`XLEN-1){1'b0}}, lt_u};
            ALU_SLL:  res_o = sll_res;
            ALU_SRL,
            ALU_SRA:  res_o = sh_out;
            default:  res_o = '0;   // hi/lo group and nop
        endcase
    end

endmodule

//--- verilog/isa_pkg.sv
//////////////////////////////////////////////////////////////////////
// instruction encodings seen by the execute stage
// ALU function codes, operand select and forwarding select
//////////////////////////////////////////////////////////////////////

package isa_pkg;

    typedef enum logic [4:0] {
        ALU_NOP   = 5'd0,
        ALU_PA    = 5'd1,   // pass operand A
        ALU_PB    = 5'd2,   // pass operand B
        ALU_ADD   = 5'd3,
        ALU_SUB   = 5'd4,
        ALU_AND   = 5'd5,
        ALU_OR    = 5'd6,
        ALU_XOR   = 5'd7,
        ALU_NOR   = 5'd8,
        ALU_SLT   = 5'd9,
        ALU_SLTU  = 5'd10,
        ALU_SLL   = 5'd11,  // shifts act on B by A
        ALU_SRL   = 5'd12,
        ALU_SRA   = 5'd13,
        ALU_MULT  = 5'd16,  // hi/lo group
        ALU_MULTU = 5'd17,
        ALU_DIV   = 5'd18,
        ALU_DIVU  = 5'd19,
        ALU_MFHI  = 5'd20,
        ALU_MFLO  = 5'd21,
        ALU_MTHI  = 5'd22,
        ALU_MTLO  = 5'd23
    } alu_func_e;

    typedef enum logic {
        OPA_RS  = 1'b0,
        OPA_EXT = 1'b1
    } opa_sel_e;

    typedef enum logic {
        OPB_RT  = 1'b0,
        OPB_EXT = 1'b1
    } opb_sel_e;

    typedef enum logic [1:0] {
        FWD_NONE = 2'd0,
        FWD_ALU  = 2'd1,    // result of the instruction one ahead
        FWD_MEM  = 2'd2     // result from the memory stage
    } fwd_sel_e;

endpackage

//--- verilog/operand_sel.sv
//////////////////////////////////////////////////////////////////////
// operand selection with forwarding
// fresh rs/rt from the bypass bus, A/B muxes and store data
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module operand_sel
    import isa_pkg::*;
    import exec_pkg::*;
(
    input  exec_req_t req_i,
    input  fwd_bus_t  fwd_i,
    output word_t     opa_o,
    output word_t     opb_o,
    output word_t     store_data_o
);

    word_t rs_fresh;
    word_t rt_fresh;

    // same bypass choice for both register operands
    function automatic word_t fwd_pick(input fwd_sel_e sel, input word_t reg_val,
                                       input fwd_bus_t fwd);
        word_t val;
        case (sel)
            FWD_ALU: val = fwd.alu_res;
            FWD_MEM: val = fwd.mem_res;
            default: val = reg_val;     // no hazard
        endcase
        return val;
    endfunction

    assign rs_fresh = fwd_pick(req_i.rs_fwd, req_i.rs, fwd_i);
    assign rt_fresh = fwd_pick(req_i.rt_fwd, req_i.rt, fwd_i);

    assign opa_o = (req_i.opa_sel == OPA_EXT) ? req_i.ext : rs_fresh;
    assign opb_o = (req_i.opb_sel == OPB_EXT) ? req_i.ext : rt_fresh;

    // stores always write the register value, never the immediate
    assign store_data_o = rt_fresh;

endmodule
